/* hw/clk_fast_defines.svh */
`ifndef CLK_FAST_DEFINES_SVH
`define CLK_FAST_DEFINES_SVH

// --------------------
// divider sizing
// --------------------

// width of every divisor and every divide count
`define CLK_DIV_W 4

// legal divisor range
// divide by 1 has no place in this unit
`define CLK_DIV_MIN 2
// largest value a 4 bit divisor holds
`define CLK_DIV_MAX 15

`endif

/* hw/clk_fast_pkg.sv */
package clk_fast_pkg;

  `include "clk_fast_defines.svh"

  // divisor or count value
  typedef logic [`CLK_DIV_W-1:0] div_t;

  // fast control states
  typedef enum logic [1:0] {
    CTL_IDLE,
    CTL_ARMED,
    CTL_RUN
  } ctl_state_e;

  // stretch generator states
  typedef enum logic [1:0] {
    STR_IDLE,
    STR_COUNT,
    STR_HOLD
  } stretch_state_e;

endpackage

/* hw/clk_fb_div.sv */
`timescale 1ns/100ps

`include "clk_fast_defines.svh"

module clk_fb_div (
  input  logic               ctu_clsp,
  input  logic               rst,
  input  clk_fast_pkg::div_t jdiv,
  output logic               align_edge,
  output logic               jbus_fb_div
);

  clk_fast_pkg::div_t count;
  clk_fast_pkg::div_t last;

  // terminal count of the feedback divider
  assign last = jdiv - clk_fast_pkg::div_t'(1);

  // last count before wrap
  // dividers released here line up with the next feedback pulse
  assign align_edge = (count == last);

  // free running, no stretch on the feedback path
  always_ff @(posedge ctu_clsp)
  begin
    if (rst)
    begin
      count       <= '0;
      jbus_fb_div <= 1'b0;
    end
    else
    begin
      count       <= align_edge ? '0 : count + clk_fast_pkg::div_t'(1);
      // pulse one cycle after count zero
      jbus_fb_div <= (count == '0);
    end
  end

  // divisor kept legal once out of reset
  a_jdiv_range : assert property (
    @(posedge ctu_clsp) disable iff (rst)
    (jdiv >= `CLK_DIV_MIN) && (jdiv <= `CLK_DIV_MAX)
  );

endmodule

/* hw/clk_domain_div.sv */
`timescale 1ns/100ps

module clk_domain_div (
  input  logic               ctu_clsp,
  input  logic               rst,
  input  logic               run,
  input  logic               hold,
  input  clk_fast_pkg::div_t div,
  output logic               dom_div
);

  clk_fast_pkg::div_t count;
  logic               cnt_zero;
  logic               cnt_last;

  assign cnt_zero = (count == '0);
  assign cnt_last = (count == div - clk_fast_pkg::div_t'(1));

  // --------------------
  // domain divide
  // --------------------

  always_ff @(posedge ctu_clsp)
  begin
    if (rst)
    begin
      count   <= '0;
      dom_div <= 1'b0;
    end
    else if (!run)
    begin
      // parked at zero so release pulses next cycle
      count   <= '0;
      dom_div <= 1'b0;
    end
    else
    begin
      // hold freezes count and suppresses the pulse
      // whole period grows by one cycle
      dom_div <= cnt_zero && !hold;
      if (!hold)
      begin
        count <= cnt_last ? '0 : count + clk_fast_pkg::div_t'(1);
      end
    end
  end

  // no pulse unless released a cycle earlier
  a_no_pulse_before_run : assert property (
    @(posedge ctu_clsp) disable iff (rst)
    dom_div |-> $past(run)
  );

endmodule

/* hw/clk_stretch_gen.sv */
`timescale 1ns/100ps

module clk_stretch_gen (
  input  logic               ctu_clsp,
  input  logic               rst,
  input  logic               run,
  input  logic               stretch_trig,
  input  logic               jbus_div,
  input  clk_fast_pkg::div_t stretch_cnt,
  output logic               hold
);

  clk_fast_pkg::stretch_state_e state;
  clk_fast_pkg::div_t           cnt;
  logic                         trig_smp;
  logic                         trig_smp_dly;
  logic                         trig_1sht;

  // --------------------
  // trigger capture
  // --------------------

  // trigger launched on jbus side
  // only safe to look at on jbus pulses
  always_ff @(posedge ctu_clsp)
  begin
    if (rst)
    begin
      trig_smp     <= 1'b0;
      trig_smp_dly <= 1'b0;
    end
    else
    begin
      if (jbus_div)
      begin
        trig_smp <= stretch_trig;
      end
      trig_smp_dly <= trig_smp;
    end
  end

  // rising sample, one cycle wide
  assign trig_1sht = trig_smp && !trig_smp_dly;

  // --------------------
  // delay and hold
  // --------------------

  always_ff @(posedge ctu_clsp)
  begin
    if (rst)
    begin
      state <= clk_fast_pkg::STR_IDLE;
      cnt   <= '0;
    end
    else
    begin
      case (state)
        clk_fast_pkg::STR_IDLE:
        begin
          // later triggers dropped until back here
          if (trig_1sht && run)
          begin
            state <= clk_fast_pkg::STR_COUNT;
            cnt   <= stretch_cnt - clk_fast_pkg::div_t'(1);
          end
        end
        clk_fast_pkg::STR_COUNT:
        begin
          if (cnt == clk_fast_pkg::div_t'(1))
          begin
            state <= clk_fast_pkg::STR_HOLD;
          end
          else
          begin
            cnt <= cnt - clk_fast_pkg::div_t'(1);
          end
        end
        clk_fast_pkg::STR_HOLD:
        begin
          state <= clk_fast_pkg::STR_IDLE;
        end
        default:
        begin
          state <= clk_fast_pkg::STR_IDLE;
        end
      endcase
    end
  end

  // single cycle freeze of every domain divider
  assign hold = (state == clk_fast_pkg::STR_HOLD);

  // each stretch costs exactly one cycle
  a_hold_one_cycle : assert property (
    @(posedge ctu_clsp) disable iff (rst)
    hold |=> !hold
  );

endmodule

/* hw/clk_fast_ctl.sv */
`timescale 1ns/100ps

module clk_fast_ctl (
  input  logic ctu_clsp,
  input  logic rst,
  input  logic start_clk,
  input  logic align_edge,
  input  logic jbus_fb_div,
  input  logic jbus_dom_div,
  output logic run,
  output logic jbus_div,
  output logic jbus_mult_rst_l
);

  clk_fast_pkg::ctl_state_e state;
  clk_fast_pkg::ctl_state_e state_nxt;
  logic                     start_smp;

  // --------------------
  // start sampling
  // --------------------

  // start_clk only looked at on feedback pulses
  always_ff @(posedge ctu_clsp)
  begin
    if (rst)
    begin
      start_smp <= 1'b0;
    end
    else if (jbus_fb_div)
    begin
      start_smp <= start_clk;
    end
  end

  // --------------------
  // run fsm
  // --------------------

  always_comb
  begin
    state_nxt = state;
    case (state)
      clk_fast_pkg::CTL_IDLE:
      begin
        if (start_smp)
        begin
          state_nxt = clk_fast_pkg::CTL_ARMED;
        end
      end
      clk_fast_pkg::CTL_ARMED:
      begin
        // start withdrawn before the edge came
        if (!start_smp)
        begin
          state_nxt = clk_fast_pkg::CTL_IDLE;
        end
        else if (align_edge)
        begin
          state_nxt = clk_fast_pkg::CTL_RUN;
        end
      end
      clk_fast_pkg::CTL_RUN:
      begin
        if (!start_smp)
        begin
          state_nxt = clk_fast_pkg::CTL_IDLE;
        end
      end
      default:
      begin
        state_nxt = clk_fast_pkg::CTL_IDLE;
      end
    endcase
  end

  always_ff @(posedge ctu_clsp)
  begin
    if (rst)
    begin
      state <= clk_fast_pkg::CTL_IDLE;
    end
    else
    begin
      state <= state_nxt;
    end
  end

  // all dividers released together
  assign run = (state == clk_fast_pkg::CTL_RUN);

  // registered run picks the jbus source
  // feedback copy stands in until release
  assign jbus_div = run ? jbus_dom_div : jbus_fb_div;

  // --------------------
  // multiplier reset
  // --------------------

  // set on first jbus pulse in run
  // cleared on the same edge that drops run
  always_ff @(posedge ctu_clsp)
  begin
    if (rst)
    begin
      jbus_mult_rst_l <= 1'b0;
    end
    else if (state_nxt != clk_fast_pkg::CTL_RUN)
    begin
      jbus_mult_rst_l <= 1'b0;
    end
    else if (run && jbus_div)
    begin
      jbus_mult_rst_l <= 1'b1;
    end
  end

  // multiplier never out of reset with dividers held
  a_mult_rst_in_run : assert property (
    @(posedge ctu_clsp) disable iff (rst)
    jbus_mult_rst_l |-> run
  );

endmodule

/* hw/clk_fast_top.sv */
`timescale 1ns/100ps

module clk_fast_top (
  input  logic               ctu_clsp,
  input  logic               rst,
  input  logic               start_clk,
  input  logic               stretch_trig,
  input  clk_fast_pkg::div_t cdiv,
  input  clk_fast_pkg::div_t ddiv,
  input  clk_fast_pkg::div_t jdiv,
  input  clk_fast_pkg::div_t stretch_cnt,
  output logic               cmp_div,
  output logic               dram_div,
  output logic               jbus_div,
  output logic               jbus_fb_div,
  output logic               jbus_mult_rst_l,
  output logic               run
);

  logic align_edge;
  logic jbus_dom_div;
  logic hold;

  // --------------------
  // feedback and control
  // --------------------

  // jbus copy for the pll feedback path
  clk_fb_div u_fb_div (
    .ctu_clsp    (ctu_clsp),
    .rst         (rst),
    .jdiv        (jdiv),
    .align_edge  (align_edge),
    .jbus_fb_div (jbus_fb_div)
  );

  clk_fast_ctl u_ctl (
    .ctu_clsp        (ctu_clsp),
    .rst             (rst),
    .start_clk       (start_clk),
    .align_edge      (align_edge),
    .jbus_fb_div     (jbus_fb_div),
    .jbus_dom_div    (jbus_dom_div),
    .run             (run),
    .jbus_div        (jbus_div),
    .jbus_mult_rst_l (jbus_mult_rst_l)
  );

  // stretch timed off the selected jbus pulse
  clk_stretch_gen u_stretch (
    .ctu_clsp     (ctu_clsp),
    .rst          (rst),
    .run          (run),
    .stretch_trig (stretch_trig),
    .jbus_div     (jbus_div),
    .stretch_cnt  (stretch_cnt),
    .hold         (hold)
  );

  // --------------------
  // domain dividers
  // --------------------

  clk_domain_div u_cmp_div (
    .ctu_clsp (ctu_clsp),
    .rst      (rst),
    .run      (run),
    .hold     (hold),
    .div      (cdiv),
    .dom_div  (cmp_div)
  );

  clk_domain_div u_dram_div (
    .ctu_clsp (ctu_clsp),
    .rst      (rst),
    .run      (run),
    .hold     (hold),
    .div      (ddiv),
    .dom_div  (dram_div)
  );

  // muxed with feedback inside control
  clk_domain_div u_jbus_div (
    .ctu_clsp (ctu_clsp),
    .rst      (rst),
    .run      (run),
    .hold     (hold),
    .div      (jdiv),
    .dom_div  (jbus_dom_div)
  );

endmodule

/* tests/clk_fast_tb.sv */
`timescale 1ns/100ps

`include "clk_fast_defines.svh"

module clk_fast_tb;

  localparam int NUM_SEGMENTS   = 20;
  localparam int SEG_BUDGET     = 400;
  localparam int TIMEOUT_CYCLES = NUM_SEGMENTS * SEG_BUDGET;

  logic               ctu_clsp;
  logic               rst;
  logic               start_clk;
  logic               stretch_trig;
  clk_fast_pkg::div_t cdiv;
  clk_fast_pkg::div_t ddiv;
  clk_fast_pkg::div_t jdiv;
  clk_fast_pkg::div_t stretch_cnt;
  logic               cmp_div;
  logic               dram_div;
  logic               jbus_div;
  logic               jbus_fb_div;
  logic               jbus_mult_rst_l;
  logic               run;

  // divisors for the segment in progress
  clk_fast_pkg::div_t seg_cdiv;
  clk_fast_pkg::div_t seg_ddiv;
  clk_fast_pkg::div_t seg_jdiv;
  clk_fast_pkg::div_t seg_scnt;

  // --------------------
  // cycle model state
  // --------------------

  int                       m_cyc      = 0;
  int                       m_fb_cnt;
  logic                     m_fb;
  logic                     m_start_smp;
  clk_fast_pkg::ctl_state_e m_state;
  logic                     m_mult;
  int                       m_cnt [3];
  // cmp, dram, jbus
  logic                     m_dom [3];
  logic                     m_trig_smp;
  logic                     m_trig_prev;
  // cycle of the pending hold or -1
  int                       m_hold_cyc = -1;

  int wd_cycles    = 0;
  int n_run_starts = 0;
  int n_holds      = 0;

  clk_fast_top DUT (
    .ctu_clsp        (ctu_clsp),
    .rst             (rst),
    .start_clk       (start_clk),
    .stretch_trig    (stretch_trig),
    .cdiv            (cdiv),
    .ddiv            (ddiv),
    .jdiv            (jdiv),
    .stretch_cnt     (stretch_cnt),
    .cmp_div         (cmp_div),
    .dram_div        (dram_div),
    .jbus_div        (jbus_div),
    .jbus_fb_div     (jbus_fb_div),
    .jbus_mult_rst_l (jbus_mult_rst_l),
    .run             (run)
  );

  initial
  begin
    ctu_clsp = 1'b0;
    forever #50 ctu_clsp = ~ctu_clsp;
  end

  // watchdog over the whole run
  always @(posedge ctu_clsp)
  begin
    wd_cycles = wd_cycles + 1;
    if (wd_cycles >= TIMEOUT_CYCLES)
    begin
      $display("test failed");
      $fatal(1, "timeout, run did not finish within %0d cycles", TIMEOUT_CYCLES);
    end
  end

  // --------------------
  // compare tasks
  // --------------------

  task automatic check_pulse(input string name, input logic exp, input logic act);
    begin
      if (act !== exp)
      begin
        $display("ERR %s exp=0x%0h act=0x%0h", name, exp, act);
        $display("test failed");
        $fatal(1, "output mismatch at model cycle %0d", m_cyc);
      end
    end
  endtask

  task automatic check_state(input clk_fast_pkg::ctl_state_e exp_state, input logic act_run);
    logic exp_run;
    begin
      // only run is visible at the top
      exp_run = (exp_state == clk_fast_pkg::CTL_RUN);
      if (act_run !== exp_run)
      begin
        $display("ERR run exp=0x%0h act=0x%0h (model state %s)",
                 exp_run, act_run, exp_state.name());
        $display("test failed");
        $fatal(1, "run mismatch at model cycle %0d", m_cyc);
      end
    end
  endtask

  task automatic check_outputs();
    logic exp_jbus;
    begin
      // feedback copy stands in while held
      exp_jbus = (m_state == clk_fast_pkg::CTL_RUN) ? m_dom[2] : m_fb;
      check_state(m_state, run);
      check_pulse("cmp_div", m_dom[0], cmp_div);
      check_pulse("dram_div", m_dom[1], dram_div);
      check_pulse("jbus_div", exp_jbus, jbus_div);
      check_pulse("jbus_fb_div", m_fb, jbus_fb_div);
      check_pulse("jbus_mult_rst_l", m_mult, jbus_mult_rst_l);
    end
  endtask

  // --------------------
  // cycle model
  // --------------------

  // advances the model over one rising edge using pre-edge inputs
  task automatic model_step();
    logic                     mrun;
    logic                     mjbus;
    logic                     malign;
    logic                     mhold;
    logic                     mrise;
    logic                     fb_old;
    clk_fast_pkg::ctl_state_e nxt;
    int                       div_v [3];
    begin
      if (rst)
      begin
        m_fb_cnt    = 0;
        m_fb        = 1'b0;
        m_start_smp = 1'b0;
        m_state     = clk_fast_pkg::CTL_IDLE;
        m_mult      = 1'b0;
        m_trig_smp  = 1'b0;
        m_trig_prev = 1'b0;
        m_hold_cyc  = -1;
        for (int i = 0; i < 3; i++)
        begin
          m_cnt[i] = 0;
          m_dom[i] = 1'b0;
        end
      end
      else
      begin
        div_v[0] = int'(cdiv);
        div_v[1] = int'(ddiv);
        div_v[2] = int'(jdiv);
        // values seen during the cycle that ends here
        mrun   = (m_state == clk_fast_pkg::CTL_RUN);
        mjbus  = mrun ? m_dom[2] : m_fb;
        malign = (m_fb_cnt == int'(jdiv) - 1);
        mhold  = (m_cyc == m_hold_cyc);
        mrise  = m_trig_smp && !m_trig_prev;
        fb_old = m_fb;

        nxt = m_state;
        case (m_state)
          clk_fast_pkg::CTL_IDLE:
          begin
            if (m_start_smp)
            begin
              nxt = clk_fast_pkg::CTL_ARMED;
            end
          end
          clk_fast_pkg::CTL_ARMED:
          begin
            if (!m_start_smp)
            begin
              nxt = clk_fast_pkg::CTL_IDLE;
            end
            else if (malign)
            begin
              nxt = clk_fast_pkg::CTL_RUN;
            end
          end
          default:
          begin
            if (!m_start_smp)
            begin
              nxt = clk_fast_pkg::CTL_IDLE;
            end
          end
        endcase

        if (mhold)
        begin
          n_holds++;
        end
        if (nxt == clk_fast_pkg::CTL_RUN && !mrun)
        begin
          n_run_starts++;
        end

        // multiplier reset lifts after first jbus pulse in run
        m_mult  = (nxt == clk_fast_pkg::CTL_RUN) && (m_mult || (mrun && mjbus));
        m_state = nxt;

        // rising trigger sample puts the hold stretch_cnt cycles later
        if (mrise && mrun && (m_hold_cyc < m_cyc))
        begin
          m_hold_cyc = m_cyc + int'(stretch_cnt);
        end

        for (int i = 0; i < 3; i++)
        begin
          if (!mrun)
          begin
            m_cnt[i] = 0;
            m_dom[i] = 1'b0;
          end
          else
          begin
            m_dom[i] = (m_cnt[i] == 0) && !mhold;
            if (!mhold)
            begin
              m_cnt[i] = (m_cnt[i] == div_v[i] - 1) ? 0 : m_cnt[i] + 1;
            end
          end
        end

        m_trig_prev = m_trig_smp;
        if (mjbus)
        begin
          m_trig_smp = stretch_trig;
        end

        m_fb     = (m_fb_cnt == 0);
        m_fb_cnt = malign ? 0 : m_fb_cnt + 1;
        if (fb_old)
        begin
          m_start_smp = start_clk;
        end
      end
      m_cyc++;
    end
  endtask

  // --------------------
  // stimulus
  // --------------------

  function automatic clk_fast_pkg::div_t rand_div();
    int span;
    begin
      span = `CLK_DIV_MAX - `CLK_DIV_MIN + 1;
      return clk_fast_pkg::div_t'(`CLK_DIV_MIN + ($urandom % span));
    end
  endfunction

  // one clock with inputs driven after the edge and outputs checked at the falling edge
  task automatic clock_cycle(input logic rst_v, input logic start_v, input logic trig_v);
    begin
      @(posedge ctu_clsp);
      model_step();
      rst          <= rst_v;
      start_clk    <= start_v;
      stretch_trig <= trig_v;
      cdiv         <= seg_cdiv;
      ddiv         <= seg_ddiv;
      jdiv         <= seg_jdiv;
      stretch_cnt  <= seg_scnt;
      @(negedge ctu_clsp);
      check_outputs();
    end
  endtask

  task automatic run_segment();
    int   idle_len;
    int   run_len;
    logic trig_v;
    begin
      seg_cdiv = rand_div();
      seg_ddiv = rand_div();
      seg_jdiv = rand_div();
      seg_scnt = rand_div();
      trig_v   = 1'b0;
      repeat (3)
      begin
        clock_cycle(1'b1, 1'b0, 1'b0);
      end
      // held phase with trigger noise that run ignores
      idle_len = 10 + ($urandom % 31);
      repeat (idle_len)
      begin
        if ($urandom % 12 == 0)
        begin
          trig_v = !trig_v;
        end
        clock_cycle(1'b0, 1'b0, trig_v);
      end
      run_len = 150 + ($urandom % 101);
      repeat (run_len)
      begin
        if ($urandom % 12 == 0)
        begin
          trig_v = !trig_v;
        end
        clock_cycle(1'b0, 1'b1, trig_v);
      end
      // start withdrawn so jbus falls back to feedback pulses
      repeat (60)
      begin
        clock_cycle(1'b0, 1'b0, 1'b0);
      end
    end
  endtask

  initial
  begin
    void'($urandom(69));
    seg_cdiv     = clk_fast_pkg::div_t'(`CLK_DIV_MIN);
    seg_ddiv     = clk_fast_pkg::div_t'(`CLK_DIV_MIN);
    seg_jdiv     = clk_fast_pkg::div_t'(`CLK_DIV_MIN);
    seg_scnt     = clk_fast_pkg::div_t'(`CLK_DIV_MIN);
    rst          = 1'b1;
    start_clk    = 1'b0;
    stretch_trig = 1'b0;
    cdiv         = seg_cdiv;
    ddiv         = seg_ddiv;
    jdiv         = seg_jdiv;
    stretch_cnt  = seg_scnt;

    for (int seg = 0; seg < NUM_SEGMENTS; seg++)
    begin
      run_segment();
    end

    if (n_run_starts == 0 || n_holds == 0)
    begin
      $display("test failed");
      $fatal(1, "stimulus never released the dividers or never caused a stretch");
    end
    else
    begin
      $display("test passed");
      $finish;
    end
  end

endmodule

/* vlog.f */
+incdir+hw
hw/clk_fast_pkg.sv
hw/clk_fb_div.sv
hw/clk_domain_div.sv
hw/clk_stretch_gen.sv
hw/clk_fast_ctl.sv
hw/clk_fast_top.sv
tests/clk_fast_tb.sv

/* Bender.yml */
package:
  name: clk_fast

export_include_dirs:
  - hw

sources:
  - include_dirs:
      - hw
    files:
      - hw/clk_fast_pkg.sv
      - hw/clk_fb_div.sv
      - hw/clk_domain_div.sv
      - hw/clk_stretch_gen.sv
      - hw/clk_fast_ctl.sv
      - hw/clk_fast_top.sv
  - target: test
    include_dirs:
      - hw
    files:
      - tests/clk_fast_tb.sv
